/* files.f */
+incdir+sim
hw/rob_pkg.sv
hw/rob_ptr.sv
hw/rob_entry.sv
hw/rob_commit.sv
hw/rob_top.sv
sim/tb_rob.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_rob -f files.f -o tb_rob; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/tb_rob)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1

/* sim/tb_rob_table.svh */
`ifndef TB_ROB_TABLE_SVH
`define TB_ROB_TABLE_SVH

// one dispatched group and the commit it should produce
// cause fields hold one 4-bit except_t per slot, slot 0 in the low nibble
typedef struct packed {
  grp_id_t                grp;
  grp_id_t                fe_valid;
  logic [4*DISP_SIZE-1:0] fe_type;
  grp_id_t                ex_valid;
  logic [4*DISP_SIZE-1:0] ex_type;
  // cycles before done reports, negative means never
  int                     delay;
  // wait for every commit before the next row
  logic                   drain;
  pc_t                    pc_base;
  grp_id_t                exp_dead;
  logic                   exp_except;
  except_t                exp_type;
  pc_t                    exp_epc;
} row_t;

localparam int NUM_ROWS = 9;

localparam row_t ROWS [NUM_ROWS] = '{
  // in-order commit, done reports out of order
  '{4'b1111, 4'b0000, 16'h0, 4'b0000, 16'h0, 8, 1'b0, 32'h1000,
    4'b0000, 1'b0, INST_ADDR_MISALIGN, 32'h0},
  '{4'b0011, 4'b0000, 16'h0, 4'b0000, 16'h0, 3, 1'b0, 32'h2000,
    4'b0000, 1'b0, INST_ADDR_MISALIGN, 32'h0},
  '{4'b0111, 4'b0000, 16'h0, 4'b0000, 16'h0, 1, 1'b1, 32'h3000,
    4'b0000, 1'b0, INST_ADDR_MISALIGN, 32'h0},
  // front-end faults in slots 2 and 3, slot 2 wins
  '{4'b1111, 4'b1100, {BREAKPOINT, INST_PAGE_FAULT, 8'h00}, 4'b0000, 16'h0, 2, 1'b1,
    32'h4000, 4'b1000, 1'b1, INST_PAGE_FAULT, 32'h4008},
  // fault in slot 0, commits with no report at all
  '{4'b0111, 4'b0001, {12'h000, INST_ACC_FAULT}, 4'b0000, 16'h0, 2, 1'b1,
    32'h5000, 4'b0110, 1'b1, INST_ACC_FAULT, 32'h5000},
  // kill sequence: older group held back
  '{4'b1111, 4'b0000, 16'h0, 4'b0000, 16'h0, 30, 1'b0, 32'h6000,
    4'b0000, 1'b0, INST_ADDR_MISALIGN, 32'h0},
  '{4'b1111, 4'b0000, 16'h0, 4'b1010, {STORE_ACC_FAULT, 4'h0, LOAD_ACC_FAULT, 4'h0}, 1,
    1'b0, 32'h7000, 4'b1100, 1'b1, LOAD_ACC_FAULT, 32'h7004},
  '{4'b0011, 4'b0000, 16'h0, 4'b0000, 16'h0, -1, 1'b0, 32'h8000,
    4'b0011, 1'b0, INST_ADDR_MISALIGN, 32'h0},
  '{4'b1111, 4'b0000, 16'h0, 4'b0000, 16'h0, -1, 1'b1, 32'h9000,
    4'b1111, 1'b0, INST_ADDR_MISALIGN, 32'h0}
};

`endif

/* sim/tb_rob.sv */
module tb_rob
  import rob_pkg::*;
();

  `include "tb_rob_table.svh"

  typedef struct packed {
    cmt_id_t                 id;
    grp_id_t                 grp;
    grp_id_t                 dead;
    logic                    exc;
    except_t                 etype;
    pc_t                     epc;
    grp_id_t                 wr;
    rnid_t   [DISP_SIZE-1:0] rn;
    rnid_t   [DISP_SIZE-1:0] old;
    regidx_t [DISP_SIZE-1:0] ri;
  } exp_t;

  logic    i_clk = 1'b0;
  logic    i_reset_n;
  logic    i_disp_valid;
  logic    o_disp_ready;
  cmt_id_t o_disp_cmt_id;
  grp_id_t i_disp_grp_id;
  pc_t     i_disp_pc              [DISP_SIZE];
  grp_id_t i_disp_wr_valid;
  rnid_t   i_disp_rnid            [DISP_SIZE];
  rnid_t   i_disp_old_rnid        [DISP_SIZE];
  regidx_t i_disp_regidx          [DISP_SIZE];
  grp_id_t i_disp_fe_except_valid;
  except_t i_disp_fe_except_type  [DISP_SIZE];
  logic    i_done_valid           [DONE_PORTS];
  cmt_id_t i_done_cmt_id          [DONE_PORTS];
  grp_id_t i_done_slot            [DONE_PORTS];
  logic    i_done_except_valid    [DONE_PORTS];
  except_t i_done_except_type     [DONE_PORTS];
  logic    o_commit_valid;
  cmt_id_t o_commit_cmt_id;
  grp_id_t o_commit_grp_id;
  grp_id_t o_commit_dead_id;
  logic    o_commit_except_valid;
  except_t o_commit_except_type;
  pc_t     o_commit_epc;
  grp_id_t o_commit_rd_valid;
  rnid_t   o_commit_rd_rnid       [DISP_SIZE];
  rnid_t   o_commit_old_rnid      [DISP_SIZE];
  regidx_t o_commit_rd_regidx     [DISP_SIZE];

  logic [31:0] rng_state;
  int          cyc;
  logic        hold_done;
  cmt_id_t     next_id;
  exp_t        model_q [$];
  // pending done reports
  cmt_id_t     q_id    [$];
  grp_id_t     q_slot  [$];
  logic        q_ev    [$];
  except_t     q_et    [$];
  int          q_due   [$];

  rob_top DUT (.*);

  always #50 i_clk = ~i_clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_cmt_id(input cmt_id_t act, input cmt_id_t exp, input string what);
    if (act !== exp)
      stop_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, what, act, exp));
  endtask

  task automatic check_grp(input grp_id_t act, input grp_id_t exp, input string what);
    if (act !== exp)
      stop_run($sformatf("FAILED at %0t: %s got %b expected %b", $time, what, act, exp));
  endtask

  task automatic check_except(input except_t act, input except_t exp, input string what);
    if (act !== exp)
      stop_run($sformatf("FAILED at %0t: %s got %0d expected %0d", $time, what, act, exp));
  endtask

  task automatic check_pc(input pc_t act, input pc_t exp, input string what);
    if (act !== exp)
      stop_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, what, act, exp));
  endtask

  task automatic check_rnid(input rnid_t act, input rnid_t exp, input string what);
    if (act !== exp)
      stop_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, what, act, exp));
  endtask

  task automatic check_regidx(input regidx_t act, input regidx_t exp, input string what);
    if (act !== exp)
      stop_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, what, act, exp));
  endtask

  task automatic check_bit(input logic act, input logic exp, input string what);
    if (act !== exp)
      stop_run($sformatf("FAILED at %0t: %s got %b expected %b", $time, what, act, exp));
  endtask

  // ------------------------------
  // done-report driver
  // ------------------------------
  always @(posedge i_clk) begin : drive_done
    int n;
    int k;
    int pick;
    for (int p = 0; p < DONE_PORTS; p++) begin
      i_done_valid[p] <= 1'b0;
      n = 0;
      if (!hold_done) begin
        foreach (q_due[i]) if (q_due[i] <= cyc) n++;
      end
      if (n > 0) begin
        // random pick among the due reports
        k    = int'(next_rand() % 32'(n));
        pick = -1;
        foreach (q_due[i]) begin
          if (q_due[i] <= cyc) begin
            if (k == 0) pick = i;
            k--;
          end
        end
        i_done_valid[p]        <= 1'b1;
        i_done_cmt_id[p]       <= q_id[pick];
        i_done_slot[p]         <= q_slot[pick];
        i_done_except_valid[p] <= q_ev[pick];
        i_done_except_type[p]  <= q_et[pick];
        q_id.delete(pick);
        q_slot.delete(pick);
        q_ev.delete(pick);
        q_et.delete(pick);
        q_due.delete(pick);
      end
    end
    cyc <= cyc + 1;
  end

  // commits checked at the falling edge against the model queue
  always @(negedge i_clk) begin : check_commit
    exp_t e;
    if (i_reset_n && o_commit_valid) begin
      if (model_q.size() == 0) begin
        stop_run("a commit appeared with no group outstanding");
      end else begin
        e = model_q.pop_front();
        check_cmt_id(o_commit_cmt_id, e.id, "commit cmt_id");
        check_grp(o_commit_grp_id, e.grp, "commit grp_id");
        check_grp(o_commit_dead_id, e.dead, "commit dead_id");
        check_bit(o_commit_except_valid, e.exc, "commit except_valid");
        if (e.exc) begin
          check_except(o_commit_except_type, e.etype, "commit except_type");
          check_pc(o_commit_epc, e.epc, "commit epc");
        end
        check_grp(o_commit_rd_valid, e.wr, "commit rd_valid");
        for (int d = 0; d < DISP_SIZE; d++) begin
          check_rnid(o_commit_rd_rnid[d], e.rn[d], "commit rd_rnid");
          check_rnid(o_commit_old_rnid[d], e.old[d], "commit old_rnid");
          check_regidx(o_commit_rd_regidx[d], e.ri[d], "commit rd_regidx");
        end
      end
    end
  end

  // ------------------------------
  // dispatch and drain
  // ------------------------------
  task automatic dispatch_row(input row_t r);
    grp_id_t tree;
    grp_id_t need;
    exp_t    e;
    int      t;
    int      due_off [DISP_SIZE];
    @(negedge i_clk);
    // slots at and above the first front-end fault are done at load
    tree[0] = r.fe_valid[0] & r.grp[0];
    for (int d = 1; d < DISP_SIZE; d++) tree[d] = tree[d-1] | (r.fe_valid[d] & r.grp[d]);
    need    = r.grp & ~tree;
    e.id    = next_id;
    e.grp   = r.grp;
    e.dead  = r.exp_dead;
    e.exc   = r.exp_except;
    e.etype = r.exp_type;
    e.epc   = r.exp_epc;
    e.wr    = grp_id_t'(next_rand());
    for (int d = 0; d < DISP_SIZE; d++) begin
      e.rn[d]  = rnid_t'(next_rand());
      e.old[d] = rnid_t'(next_rand());
      e.ri[d]  = regidx_t'(next_rand());
    end
    // per-slot spread of the report delay
    for (int d = 0; d < DISP_SIZE; d++) begin
      due_off[d] = int'(next_rand() % 32'd3);
    end
    model_q.push_back(e);
    @(posedge i_clk);
    i_disp_valid           <= 1'b1;
    i_disp_grp_id          <= r.grp;
    i_disp_wr_valid        <= e.wr;
    i_disp_fe_except_valid <= r.fe_valid;
    for (int d = 0; d < DISP_SIZE; d++) begin
      i_disp_pc[d]             <= r.pc_base + pc_t'(4 * d);
      i_disp_rnid[d]           <= e.rn[d];
      i_disp_old_rnid[d]       <= e.old[d];
      i_disp_regidx[d]         <= e.ri[d];
      i_disp_fe_except_type[d] <= except_t'(r.fe_type[4*d +: 4]);
    end
    // group stays presented until the DUT has room
    t = 0;
    @(negedge i_clk);
    while (!o_disp_ready) begin
      t++;
      if (t > 200) stop_run("timeout: dispatch ready never returned");
      @(negedge i_clk);
    end
    check_cmt_id(o_disp_cmt_id, next_id, "dispatch cmt_id");
    @(posedge i_clk);
    i_disp_valid <= 1'b0;
    if (r.delay >= 0) begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (need[d]) begin
          q_id.push_back(next_id);
          q_slot.push_back(grp_id_t'(1 << d));
          q_ev.push_back(r.ex_valid[d]);
          q_et.push_back(except_t'(r.ex_type[4*d +: 4]));
          q_due.push_back(cyc + r.delay + due_off[d]);
        end
      end
    end
    next_id = next_id + cmt_id_t'(1);
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (model_q.size() != 0) begin
      @(posedge i_clk);
      t++;
      if (t > 300) stop_run("timeout: expected commits did not all appear");
    end
    @(negedge i_clk);
  endtask

  initial begin
    rng_state              = 32'hd8a3;
    cyc                    = 0;
    hold_done              = 1'b0;
    next_id                = '0;
    i_reset_n              = 1'b0;
    i_disp_valid           = 1'b0;
    i_disp_grp_id          = '0;
    i_disp_wr_valid        = '0;
    i_disp_fe_except_valid = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      i_disp_pc[d]             = '0;
      i_disp_rnid[d]           = '0;
      i_disp_old_rnid[d]       = '0;
      i_disp_regidx[d]         = '0;
      i_disp_fe_except_type[d] = INST_ADDR_MISALIGN;
    end
    for (int p = 0; p < DONE_PORTS; p++) begin
      i_done_valid[p]        = 1'b0;
      i_done_cmt_id[p]       = '0;
      i_done_slot[p]         = '0;
      i_done_except_valid[p] = 1'b0;
      i_done_except_type[p]  = INST_ADDR_MISALIGN;
    end
    repeat (4) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(negedge i_clk);
    check_bit(o_commit_valid, 1'b0, "commit_valid after reset");
    check_bit(o_commit_except_valid, 1'b0, "except_valid after reset");
    check_bit(o_disp_ready, 1'b1, "disp_ready after reset");

    for (int r = 0; r < NUM_ROWS; r++) begin
      dispatch_row(ROWS[r]);
      if (ROWS[r].drain) wait_drain();
    end

    // fill the buffer with no completions
    hold_done = 1'b1;
    for (int i = 0; i < CMT_ENTRY_SIZE; i++) begin
      dispatch_row(ROWS[0]);
      @(negedge i_clk);
      check_bit(o_disp_ready, i < CMT_ENTRY_SIZE - 1, "disp_ready while filling");
    end
    // one more group waits on ready until completions resume
    fork
      dispatch_row(ROWS[0]);
      begin
        repeat (4) @(negedge i_clk);
        check_bit(o_disp_ready, 1'b0, "disp_ready with a group held");
        check_cmt_id(o_disp_cmt_id, next_id, "dispatch cmt_id with a group held");
        hold_done = 1'b0;
      end
    join
    wait_drain();
    @(negedge i_clk);
    check_bit(o_disp_ready, 1'b1, "disp_ready after drain");

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* hw/rob_top.sv */
module rob_top
  import rob_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_reset_n,
  // dispatch
  input  logic    i_disp_valid,
  output logic    o_disp_ready,
  output cmt_id_t o_disp_cmt_id,
  input  grp_id_t i_disp_grp_id,
  input  pc_t     i_disp_pc              [DISP_SIZE],
  input  grp_id_t i_disp_wr_valid,
  input  rnid_t   i_disp_rnid            [DISP_SIZE],
  input  rnid_t   i_disp_old_rnid        [DISP_SIZE],
  input  regidx_t i_disp_regidx          [DISP_SIZE],
  input  grp_id_t i_disp_fe_except_valid,
  input  except_t i_disp_fe_except_type  [DISP_SIZE],
  // completion
  input  logic    i_done_valid           [DONE_PORTS],
  input  cmt_id_t i_done_cmt_id          [DONE_PORTS],
  input  grp_id_t i_done_slot            [DONE_PORTS],
  input  logic    i_done_except_valid    [DONE_PORTS],
  input  except_t i_done_except_type     [DONE_PORTS],
  // commit
  output logic    o_commit_valid,
  output cmt_id_t o_commit_cmt_id,
  output grp_id_t o_commit_grp_id,
  output grp_id_t o_commit_dead_id,
  output logic    o_commit_except_valid,
  output except_t o_commit_except_type,
  output pc_t     o_commit_epc,
  output grp_id_t o_commit_rd_valid,
  output rnid_t   o_commit_rd_rnid       [DISP_SIZE],
  output rnid_t   o_commit_old_rnid      [DISP_SIZE],
  output regidx_t o_commit_rd_regidx     [DISP_SIZE]
);

  cmt_id_t                   w_in_ptr;
  cmt_id_t                   w_out_ptr;
  logic                      w_accept;
  logic                      w_kill;
  logic                      w_head_done;
  grp_id_t                   w_fe_valid;
  grp_id_t                   w_fe_tree;
  grp_id_t                   w_fe_first;
  rob_entry_t                w_entry_in;
  rob_entry_t                w_entries  [CMT_ENTRY_SIZE];
  logic [CMT_ENTRY_SIZE-1:0] w_all_done;

  assign w_accept      = i_disp_valid & o_disp_ready;
  assign o_disp_cmt_id = w_in_ptr;

  // ------------------------------
  // front-end exception tree
  // ------------------------------
  assign w_fe_valid = i_disp_fe_except_valid & i_disp_grp_id;

  // slot is covered once any lower or equal slot faulted
  always_comb begin
    w_fe_tree[0] = w_fe_valid[0];
    for (int d = 1; d < DISP_SIZE; d++) begin
      w_fe_tree[d] = w_fe_tree[d-1] | w_fe_valid[d];
    end
  end
  assign w_fe_first = w_fe_tree & ~(w_fe_tree << 1);

  always_comb begin
    w_entry_in              = '0;
    w_entry_in.valid        = 1'b1;
    w_entry_in.grp_id       = i_disp_grp_id;
    w_entry_in.done_grp_id  = w_fe_tree & i_disp_grp_id;
    w_entry_in.except_valid = w_fe_first;
    w_entry_in.wr_valid     = i_disp_wr_valid;
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_entry_in.except_type[d] = i_disp_fe_except_type[d];
      w_entry_in.pc[d]          = i_disp_pc[d];
      w_entry_in.rnid[d]        = i_disp_rnid[d];
      w_entry_in.old_rnid[d]    = i_disp_old_rnid[d];
      w_entry_in.regidx[d]      = i_disp_regidx[d];
    end
  end

  // ------------------------------
  // pointers and entries
  // ------------------------------
  assign w_head_done = w_all_done[w_out_ptr[CMT_ENTRY_W-1:0]];

  rob_ptr u_ptr (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_in_valid  (w_accept),
    .i_out_valid (w_head_done),
    .o_in_ptr    (w_in_ptr),
    .o_out_ptr   (w_out_ptr),
    .o_ready     (o_disp_ready)
  );

  for (genvar c = 0; c < CMT_ENTRY_SIZE; c++) begin : g_entry
    rob_entry u_entry (
      .i_clk               (i_clk),
      .i_reset_n           (i_reset_n),
      .i_cmt_id            ({w_in_ptr[CMT_ENTRY_W], CMT_ENTRY_W'(c)}),
      .i_load_valid        (w_accept & (w_in_ptr[CMT_ENTRY_W-1:0] == CMT_ENTRY_W'(c))),
      .i_entry_in          (w_entry_in),
      .i_done_valid        (i_done_valid),
      .i_done_cmt_id       (i_done_cmt_id),
      .i_done_slot         (i_done_slot),
      .i_done_except_valid (i_done_except_valid),
      .i_done_except_type  (i_done_except_type),
      .i_kill              (w_kill),
      .i_retire            (w_head_done & (w_out_ptr[CMT_ENTRY_W-1:0] == CMT_ENTRY_W'(c))),
      .o_entry             (w_entries[c]),
      .o_all_done          (w_all_done[c])
    );
  end

  rob_commit u_commit (
    .i_clk                 (i_clk),
    .i_reset_n             (i_reset_n),
    .i_head_entry          (w_entries[w_out_ptr[CMT_ENTRY_W-1:0]]),
    .i_head_cmt_id         (w_out_ptr),
    .i_head_done           (w_head_done),
    .o_kill                (w_kill),
    .o_commit_valid        (o_commit_valid),
    .o_commit_cmt_id       (o_commit_cmt_id),
    .o_commit_grp_id       (o_commit_grp_id),
    .o_commit_dead_id      (o_commit_dead_id),
    .o_commit_except_valid (o_commit_except_valid),
    .o_commit_except_type  (o_commit_except_type),
    .o_commit_epc          (o_commit_epc),
    .o_commit_rd_valid     (o_commit_rd_valid),
    .o_commit_rd_rnid      (o_commit_rd_rnid),
    .o_commit_old_rnid     (o_commit_old_rnid),
    .o_commit_rd_regidx    (o_commit_rd_regidx)
  );

endmodule

/* hw/rob_commit.sv */
module rob_commit
  import rob_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  rob_entry_t i_head_entry,
  input  cmt_id_t    i_head_cmt_id,
  input  logic       i_head_done,
  output logic       o_kill,
  output logic       o_commit_valid,
  output cmt_id_t    o_commit_cmt_id,
  output grp_id_t    o_commit_grp_id,
  output grp_id_t    o_commit_dead_id,
  output logic       o_commit_except_valid,
  output except_t    o_commit_except_type,
  output pc_t        o_commit_epc,
  output grp_id_t    o_commit_rd_valid,
  output rnid_t      o_commit_rd_rnid   [DISP_SIZE],
  output rnid_t      o_commit_old_rnid  [DISP_SIZE],
  output regidx_t    o_commit_rd_regidx [DISP_SIZE]
);

  grp_id_t w_live_except;
  grp_id_t w_younger;
  grp_id_t w_dead_id;
  logic    w_except;
  except_t w_except_type;
  pc_t     w_epc;

  // ------------------------------
  // exception slot selection
  // ------------------------------
  // ignore dead slots and slots outside the group
  assign w_live_except = i_head_entry.except_valid & i_head_entry.grp_id &
                         ~i_head_entry.dead_grp_id;
  assign w_except      = |w_live_except;

  // lowest live exception wins, everything above it dies
  always_comb begin
    logic seen;
    seen          = 1'b0;
    w_younger     = '0;
    w_except_type = INST_ADDR_MISALIGN;
    w_epc         = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_younger[d] = seen & i_head_entry.grp_id[d];
      if (w_live_except[d] && !seen) begin
        w_except_type = i_head_entry.except_type[d];
        w_epc         = i_head_entry.pc[d];
      end
      seen = seen | w_live_except[d];
    end
  end

  assign w_dead_id = (i_head_entry.dead_grp_id | w_younger) & i_head_entry.grp_id;

  // flush all younger entries in the retire cycle
  assign o_kill = i_head_done & w_except;

  // ------------------------------
  // registered commit outputs
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_commit_valid        <= 1'b0;
      o_commit_except_valid <= 1'b0;
    end else begin
      o_commit_valid        <= i_head_done;
      o_commit_except_valid <= i_head_done & w_except;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_head_done) begin
      o_commit_cmt_id      <= i_head_cmt_id;
      o_commit_grp_id      <= i_head_entry.grp_id;
      o_commit_dead_id     <= w_dead_id;
      o_commit_except_type <= w_except_type;
      o_commit_epc         <= w_epc;
      // rename update, qualified by dead_id downstream
      o_commit_rd_valid    <= i_head_entry.wr_valid;
      for (int d = 0; d < DISP_SIZE; d++) begin
        o_commit_rd_rnid[d]   <= i_head_entry.rnid[d];
        o_commit_old_rnid[d]  <= i_head_entry.old_rnid[d];
        o_commit_rd_regidx[d] <= i_head_entry.regidx[d];
      end
    end
  end

endmodule

/* hw/rob_entry.sv */
module rob_entry
  import rob_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  cmt_id_t    i_cmt_id,
  input  logic       i_load_valid,
  input  rob_entry_t i_entry_in,
  input  logic       i_done_valid        [DONE_PORTS],
  input  cmt_id_t    i_done_cmt_id       [DONE_PORTS],
  input  grp_id_t    i_done_slot         [DONE_PORTS],
  input  logic       i_done_except_valid [DONE_PORTS],
  input  except_t    i_done_except_type  [DONE_PORTS],
  input  logic       i_kill,
  input  logic       i_retire,
  output rob_entry_t o_entry,
  output logic       o_all_done
);

  // control state
  logic                  r_valid;
  grp_id_t               r_done;
  grp_id_t               r_dead;
  grp_id_t               r_except_valid;

  // payload, only meaningful while r_valid
  rob_entry_t            r_payload;
  cmt_id_t               r_cmt_id;

  logic [DONE_PORTS-1:0] w_done_hit;
  grp_id_t               w_done_set;
  grp_id_t               w_except_set;
  grp_id_t               w_kill_grp;

  // ------------------------------
  // completion report match
  // ------------------------------
  for (genvar p = 0; p < DONE_PORTS; p++) begin : g_done
    // full id compare so a stale wrap never hits
    assign w_done_hit[p] = r_valid & i_done_valid[p] & (i_done_cmt_id[p] == r_cmt_id);

    a_done_to_valid : assert property (@(posedge i_clk) disable iff (!i_reset_n)
      i_done_valid[p] && (i_done_cmt_id[p][CMT_ENTRY_W-1:0] == i_cmt_id[CMT_ENTRY_W-1:0])
      |-> r_valid);
  end

  always_comb begin
    w_done_set   = '0;
    w_except_set = '0;
    for (int p = 0; p < DONE_PORTS; p++) begin
      if (w_done_hit[p]) begin
        w_done_set = w_done_set | i_done_slot[p];
        if (i_done_except_valid[p]) begin
          w_except_set = w_except_set | i_done_slot[p];
        end
      end
    end
  end

  // a kill in the load cycle hits the incoming group
  assign w_kill_grp = !i_kill      ? '0 :
                      i_load_valid ? i_entry_in.grp_id :
                                     r_payload.grp_id;

  // ------------------------------
  // state update
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid        <= 1'b0;
      r_done         <= '0;
      r_dead         <= '0;
      r_except_valid <= '0;
    end else if (i_load_valid) begin
      r_valid        <= 1'b1;
      r_done         <= i_entry_in.done_grp_id | w_kill_grp;
      r_dead         <= i_entry_in.dead_grp_id | w_kill_grp;
      r_except_valid <= i_entry_in.except_valid;
    end else if (i_retire) begin
      r_valid <= 1'b0;
    end else if (r_valid) begin
      r_done         <= r_done | w_done_set | w_kill_grp;
      r_dead         <= r_dead | w_kill_grp;
      r_except_valid <= r_except_valid | w_except_set;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load_valid) begin
      r_payload <= i_entry_in;
      r_cmt_id  <= i_cmt_id;
    end else begin
      for (int p = 0; p < DONE_PORTS; p++) begin
        for (int d = 0; d < DISP_SIZE; d++) begin
          if (w_done_hit[p] && i_done_except_valid[p] && i_done_slot[p][d]) begin
            r_payload.except_type[d] <= i_done_except_type[p];
          end
        end
      end
    end
  end

  always_comb begin
    o_entry              = r_payload;
    o_entry.valid        = r_valid;
    o_entry.done_grp_id  = r_done;
    o_entry.dead_grp_id  = r_dead;
    o_entry.except_valid = r_except_valid;
  end

  // every slot of the group finished or killed
  assign o_all_done = r_valid & ((r_payload.grp_id & ~(r_done | r_dead)) == '0);

  a_no_load_when_valid : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_load_valid |-> !r_valid);

endmodule

/* hw/rob_ptr.sv */
module rob_ptr
  import rob_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_reset_n,
  input  logic    i_in_valid,
  input  logic    i_out_valid,
  output cmt_id_t o_in_ptr,
  output cmt_id_t o_out_ptr,
  output logic    o_ready
);

  cmt_id_t             r_in_ptr;
  cmt_id_t             r_out_ptr;
  logic [CMT_ID_W-1:0] w_count;
  logic                w_full;
  logic                w_empty;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
    end else begin
      if (i_in_valid) begin
        r_in_ptr <= r_in_ptr + CMT_ID_W'(1);
      end
      if (i_out_valid) begin
        r_out_ptr <= r_out_ptr + CMT_ID_W'(1);
      end
    end
  end

  // wrap bit makes the difference range 0..CMT_ENTRY_SIZE
  assign w_count = r_in_ptr - r_out_ptr;
  assign w_full  = (w_count == CMT_ID_W'(CMT_ENTRY_SIZE));
  assign w_empty = (w_count == '0);

  assign o_in_ptr  = r_in_ptr;
  assign o_out_ptr = r_out_ptr;
  assign o_ready   = !w_full;

  // dispatch handshake in the top must respect ready
  a_no_in_when_full : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_in_valid |-> !w_full);

  // head all-done can only come from a valid entry
  a_no_out_when_empty : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_out_valid |-> !w_empty);

endmodule

/* hw/rob_pkg.sv */
package rob_pkg;

  // ------------------------------
  // sizing
  // ------------------------------
  localparam int DISP_SIZE      = 4;
  localparam int CMT_ENTRY_SIZE = 8;
  localparam int CMT_ENTRY_W    = 3;
  // entry index plus wrap bit
  localparam int CMT_ID_W       = CMT_ENTRY_W + 1;
  localparam int DONE_PORTS     = 2;
  localparam int RNID_W         = 6;
  localparam int REGIDX_W       = 5;
  localparam int PC_W           = 32;

  // ------------------------------
  // shared types
  // ------------------------------
  // msb is the wrap bit, low bits index the buffer
  typedef logic [CMT_ID_W-1:0]  cmt_id_t;
  // one bit per slot of a dispatch group
  typedef logic [DISP_SIZE-1:0] grp_id_t;
  typedef logic [RNID_W-1:0]    rnid_t;
  typedef logic [REGIDX_W-1:0]  regidx_t;
  typedef logic [PC_W-1:0]      pc_t;

  // risc-v style cause codes
  typedef enum logic [3:0] {
    INST_ADDR_MISALIGN  = 4'd0,
    INST_ACC_FAULT      = 4'd1,
    ILLEGAL_INST        = 4'd2,
    BREAKPOINT          = 4'd3,
    LOAD_ADDR_MISALIGN  = 4'd4,
    LOAD_ACC_FAULT      = 4'd5,
    STORE_ADDR_MISALIGN = 4'd6,
    STORE_ACC_FAULT     = 4'd7,
    ECALL_M             = 4'd11,
    INST_PAGE_FAULT     = 4'd12
  } except_t;

  // one buffer entry, a whole dispatch group
  typedef struct packed {
    logic                    valid;
    grp_id_t                 grp_id;
    grp_id_t                 done_grp_id;
    grp_id_t                 dead_grp_id;
    grp_id_t                 except_valid;
    except_t [DISP_SIZE-1:0] except_type;
    pc_t     [DISP_SIZE-1:0] pc;
    // destination register per slot
    grp_id_t                 wr_valid;
    rnid_t   [DISP_SIZE-1:0] rnid;
    rnid_t   [DISP_SIZE-1:0] old_rnid;
    regidx_t [DISP_SIZE-1:0] regidx;
  } rob_entry_t;

endpackage
